//--- verilog/core_pkg.sv
package core_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;
    // One shift-add step per multiplier bit
    localparam int MULT_CYCLES   = 32;

    // Data word, also the raw instruction
    typedef logic [31:0]                      word_t;
    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_tag_t;
    // ROB slot index at the default depth of 8
    typedef logic [2:0]                       rob_idx_t;

    ////////////////////
    // RV32 encodings
    ////////////////////

    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_MUL     = 3'b000;
    localparam logic [2:0] F3_ADDI    = 3'b000;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;
    // M extension
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    // Decoded operation
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,
        OP_ADDI,
        OP_NONE
    } op_t;

    // Dispatch FSM
    typedef enum logic [0:0] {
        ST_IDLE,
        ST_MULT
    } ctrl_state_t;

endpackage

//--- verilog/rob_write_if.sv
`timescale 1ns/100ps

// Finished instruction, execution to ROB tail
interface rob_write_if;

    // One-cycle strobe, written at that edge
    logic                valid;
    core_pkg::arch_reg_t rd;
    logic                has_dest;
    core_pkg::phys_tag_t new_tag;
    // Previous mapping of rd, freed at retire
    core_pkg::phys_tag_t old_tag;
    core_pkg::word_t     result;

    // Execution side
    modport source (
        output valid, rd, has_dest, new_tag, old_tag, result
    );

    // Reorder buffer side
    modport sink (
        input valid, rd, has_dest, new_tag, old_tag, result
    );

endinterface

//--- verilog/dispatch_ctrl.sv
`timescale 1ns/100ps

module dispatch_ctrl #(
    parameter int ROB_DEPTH = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic instr_valid,
    input  logic is_mult,
    input  logic rob_full,
    input  logic mult_done,
    input  logic alu_done,
    output logic accept,
    output logic mult_start
);

    localparam int PEND_W = $clog2(ROB_DEPTH + 1);

    core_pkg::ctrl_state_t state;
    core_pkg::ctrl_state_t state_next;
    // Low in reset and the cycle after it
    logic                  run_en;
    // Accepted but not yet finished
    logic [PEND_W-1:0]     pending;

    // Consume the offered instruction only when idle and a slot is free
    assign accept = run_en && (state == core_pkg::ST_IDLE) && instr_valid
                    && !rob_full && (pending < PEND_W'(ROB_DEPTH));
    assign mult_start = accept && is_mult;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        state_next = state;
        case (state)
            core_pkg::ST_IDLE: begin
                // Block dispatch for the whole multiply
                if (mult_start) begin
                    state_next = core_pkg::ST_MULT;
                end
            end
            core_pkg::ST_MULT: begin
                if (mult_done) begin
                    state_next = core_pkg::ST_IDLE;
                end
            end
            default: state_next = core_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= core_pkg::ST_IDLE;
            run_en  <= 1'b0;
            pending <= '0;
        end else begin
            state   <= state_next;
            run_en  <= 1'b1;
            // ALU work finishes in its accept cycle, so nets to zero
            pending <= pending + PEND_W'(accept) - PEND_W'(alu_done || mult_done);
        end
    end

endmodule

//--- verilog/mult_counter.sv
`timescale 1ns/100ps

module mult_counter (
    input  logic clock,
    input  logic reset,
    input  logic mult_start,
    output logic mult_busy,
    output logic mult_done
);

    localparam int CNT_W = $clog2(core_pkg::MULT_CYCLES + 1);

    // Shift-add steps still to go
    logic [CNT_W-1:0] count;

    // One multiplier step per busy cycle
    assign mult_busy = (count != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            count     <= '0;
            mult_done <= 1'b0;
        end else begin
            // Pulse in the cycle after the last step
            mult_done <= (count == CNT_W'(1));
            if (mult_start) begin
                count <= CNT_W'(core_pkg::MULT_CYCLES);
            end else if (mult_busy) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- verilog/rename_unit.sv
`timescale 1ns/100ps

module rename_unit (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::word_t     instr,
    input  logic                accept,
    input  logic                free_valid,
    input  core_pkg::phys_tag_t free_tag,
    output core_pkg::op_t       op,
    output logic                is_mult,
    output core_pkg::phys_tag_t src1_tag,
    output core_pkg::phys_tag_t src2_tag,
    output core_pkg::word_t     imm,
    output core_pkg::arch_reg_t rd,
    output logic                has_dest,
    output core_pkg::phys_tag_t new_tag,
    output core_pkg::phys_tag_t old_tag
);

    // Spare tags beyond the architected set
    localparam int FREE_DEPTH = core_pkg::NUM_PHYS_REGS - core_pkg::NUM_ARCH_REGS;

    typedef logic [$clog2(FREE_DEPTH)-1:0] free_ptr_t;

    core_pkg::phys_tag_t map_table [core_pkg::NUM_ARCH_REGS];
    core_pkg::phys_tag_t free_list [FREE_DEPTH];
    free_ptr_t           free_head;
    free_ptr_t           free_tail;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    core_pkg::arch_reg_t rs1;
    core_pkg::arch_reg_t rs2;

    ////////////////////
    // Decode
    ////////////////////

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    // Sign-extended I immediate
    assign imm    = {{20{instr[31]}}, instr[31:20]};

    always_comb begin
        op = core_pkg::OP_NONE;
        if (opcode == core_pkg::OPC_RTYPE) begin
            case ({funct7, funct3})
                {core_pkg::F7_BASE,   core_pkg::F3_ADD_SUB}: op = core_pkg::OP_ADD;
                {core_pkg::F7_SUB,    core_pkg::F3_ADD_SUB}: op = core_pkg::OP_SUB;
                {core_pkg::F7_BASE,   core_pkg::F3_AND}:     op = core_pkg::OP_AND;
                {core_pkg::F7_BASE,   core_pkg::F3_OR}:      op = core_pkg::OP_OR;
                {core_pkg::F7_BASE,   core_pkg::F3_XOR}:     op = core_pkg::OP_XOR;
                {core_pkg::F7_MULDIV, core_pkg::F3_MUL}:     op = core_pkg::OP_MUL;
                default:                                     op = core_pkg::OP_NONE;
            endcase
        end else if (opcode == core_pkg::OPC_ITYPE && funct3 == core_pkg::F3_ADDI) begin
            op = core_pkg::OP_ADDI;
        end
    end

    assign is_mult  = (op == core_pkg::OP_MUL);
    // x0 and unknown opcodes never take a tag
    assign has_dest = (op != core_pkg::OP_NONE) && (rd != '0);

    ////////////////////
    // Rename
    ////////////////////

    assign src1_tag = map_table[rs1];
    assign src2_tag = map_table[rs2];
    assign old_tag  = map_table[rd];
    assign new_tag  = free_list[free_head];

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, tags 32 to 63 free
            for (int i = 0; i < core_pkg::NUM_ARCH_REGS; i++) begin
                map_table[i] <= core_pkg::phys_tag_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_list[i] <= core_pkg::phys_tag_t'(core_pkg::NUM_ARCH_REGS + i);
            end
            free_head <= '0;
            free_tail <= '0;
        end else begin
            if (accept && has_dest) begin
                map_table[rd] <= new_tag;
                free_head     <= free_head + 1'b1;
            end
            // Retired old mapping goes back on the list
            if (free_valid) begin
                free_list[free_tail] <= free_tag;
                free_tail            <= free_tail + 1'b1;
            end
        end
    end

endmodule

//--- verilog/exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
    input  logic                clock,
    input  logic                reset,
    input  logic                accept,
    input  core_pkg::op_t       op,
    input  core_pkg::phys_tag_t src1_tag,
    input  core_pkg::phys_tag_t src2_tag,
    input  core_pkg::word_t     imm,
    input  core_pkg::arch_reg_t rd,
    input  logic                has_dest,
    input  core_pkg::phys_tag_t new_tag,
    input  core_pkg::phys_tag_t old_tag,
    input  logic                mult_start,
    input  logic                mult_busy,
    input  logic                mult_done,
    output logic                alu_done,
    rob_write_if.source         rob_wr
);

    core_pkg::word_t     prf [core_pkg::NUM_PHYS_REGS];
    core_pkg::word_t     src1_val;
    core_pkg::word_t     src2_val;
    core_pkg::word_t     alu_result;

    // Multiplier operands, partial product and held destination
    core_pkg::word_t     m_cand;
    core_pkg::word_t     m_plier;
    core_pkg::word_t     m_acc;
    core_pkg::arch_reg_t m_rd;
    logic                m_has_dest;
    core_pkg::phys_tag_t m_new_tag;
    core_pkg::phys_tag_t m_old_tag;

    // No producer is ever outstanding at a read
    assign src1_val = prf[src1_tag];
    assign src2_val = prf[src2_tag];

    ////////////////////
    // ALU
    ////////////////////

    always_comb begin
        case (op)
            core_pkg::OP_ADD:  alu_result = src1_val + src2_val;
            core_pkg::OP_SUB:  alu_result = src1_val - src2_val;
            core_pkg::OP_AND:  alu_result = src1_val & src2_val;
            core_pkg::OP_OR:   alu_result = src1_val | src2_val;
            core_pkg::OP_XOR:  alu_result = src1_val ^ src2_val;
            core_pkg::OP_ADDI: alu_result = src1_val + imm;
            default:           alu_result = '0;
        endcase
    end

    // Everything but a multiply finishes at its accept edge
    assign alu_done = accept && (op != core_pkg::OP_MUL);

    ////////////////////
    // Shift-add multiplier
    ////////////////////

    always_ff @(posedge clock) begin
        if (mult_start) begin
            m_cand     <= src1_val;
            m_plier    <= src2_val;
            m_acc      <= '0;
            m_rd       <= rd;
            m_has_dest <= has_dest;
            m_new_tag  <= new_tag;
            m_old_tag  <= old_tag;
        end else if (mult_busy) begin
            if (m_plier[0]) begin
                m_acc <= m_acc + m_cand;
            end
            m_cand  <= m_cand << 1;
            m_plier <= m_plier >> 1;
        end
    end

    // Finish port, multiply result wins in its done cycle
    assign rob_wr.valid = alu_done || mult_done;

    always_comb begin
        if (mult_done) begin
            rob_wr.rd       = m_rd;
            rob_wr.has_dest = m_has_dest;
            rob_wr.new_tag  = m_new_tag;
            rob_wr.old_tag  = m_old_tag;
            rob_wr.result   = m_acc;
        end else begin
            rob_wr.rd       = rd;
            rob_wr.has_dest = has_dest;
            rob_wr.new_tag  = new_tag;
            rob_wr.old_tag  = old_tag;
            rob_wr.result   = alu_result;
        end
    end

    // PRF write at the finish edge
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::NUM_PHYS_REGS; i++) begin
                prf[i] <= '0;
            end
        end else if (rob_wr.valid && rob_wr.has_dest) begin
            prf[rob_wr.new_tag] <= rob_wr.result;
        end
    end

endmodule

//--- verilog/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                clock,
    input  logic                reset,
    rob_write_if.sink           rob_wr,
    output logic                rob_full,
    output logic                free_valid,
    output core_pkg::phys_tag_t free_tag,
    output logic                commit_valid,
    output core_pkg::arch_reg_t commit_rd,
    output logic                commit_has_dest,
    output core_pkg::word_t     commit_data
);

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    // Slot index sized by the depth
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

    core_pkg::arch_reg_t entry_rd       [ROB_DEPTH];
    logic                entry_has_dest [ROB_DEPTH];
    core_pkg::phys_tag_t entry_old_tag  [ROB_DEPTH];
    core_pkg::word_t     entry_result   [ROB_DEPTH];

    rob_idx_t            head;
    rob_idx_t            tail;
    logic [CNT_W-1:0]    count;
    logic                retire;

    // Oldest entry leaves every cycle it is present
    assign retire = (count != '0);

    // A multiply in flight blocks dispatch, so its reserved slot stays free
    assign rob_full = (count == CNT_W'(ROB_DEPTH));

    // Old tag back to the free list at the retire edge
    assign free_valid = retire && entry_has_dest[head];
    assign free_tag   = entry_old_tag[head];

    // Tail write
    always_ff @(posedge clock) begin
        if (rob_wr.valid) begin
            entry_rd[tail]       <= rob_wr.rd;
            entry_has_dest[tail] <= rob_wr.has_dest;
            entry_old_tag[tail]  <= rob_wr.old_tag;
            entry_result[tail]   <= rob_wr.result;
        end
    end

    ////////////////////
    // Pointers and commit
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (rob_wr.valid) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(rob_wr.valid) - CNT_W'(retire);
        end
    end

    // Commit payload, qualified by commit_valid
    always_ff @(posedge clock) begin
        if (retire) begin
            commit_rd       <= entry_rd[head];
            commit_has_dest <= entry_has_dest[head];
            commit_data     <= entry_result[head];
        end
    end

endmodule

//--- verilog/core_top.sv
`timescale 1ns/100ps

module core_top #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::word_t     instr,
    input  logic                instr_valid,
    output logic                instr_taken,
    output logic                commit_valid,
    output core_pkg::arch_reg_t commit_rd,
    output logic                commit_has_dest,
    output core_pkg::word_t     commit_data
);

    // Dispatch and multiplier control
    logic                accept;
    logic                mult_start;
    logic                mult_busy;
    logic                mult_done;
    logic                alu_done;
    logic                rob_full;

    // Renamed instruction
    core_pkg::op_t       op;
    logic                is_mult;
    core_pkg::phys_tag_t src1_tag;
    core_pkg::phys_tag_t src2_tag;
    core_pkg::word_t     imm;
    core_pkg::arch_reg_t rd;
    logic                has_dest;
    core_pkg::phys_tag_t new_tag;
    core_pkg::phys_tag_t old_tag;

    // Retire to free list
    logic                free_valid;
    core_pkg::phys_tag_t free_tag;

    rob_write_if rob_wr_bus ();

    ////////////////////
    // Control
    ////////////////////

    dispatch_ctrl #(
        .ROB_DEPTH(ROB_DEPTH)
    ) dispatch_ctrl_0 (
        .clock      (clock),
        .reset      (reset),
        .instr_valid(instr_valid),
        .is_mult    (is_mult),
        .rob_full   (rob_full),
        .mult_done  (mult_done),
        .alu_done   (alu_done),
        .accept     (accept),
        .mult_start (mult_start)
    );

    mult_counter mult_counter_0 (
        .clock     (clock),
        .reset     (reset),
        .mult_start(mult_start),
        .mult_busy (mult_busy),
        .mult_done (mult_done)
    );

    // Instruction consumed at this edge
    assign instr_taken = accept;

    ////////////////////
    // Datapath
    ////////////////////

    rename_unit rename_unit_0 (
        .clock     (clock),
        .reset     (reset),
        .instr     (instr),
        .accept    (accept),
        .free_valid(free_valid),
        .free_tag  (free_tag),
        .op        (op),
        .is_mult   (is_mult),
        .src1_tag  (src1_tag),
        .src2_tag  (src2_tag),
        .imm       (imm),
        .rd        (rd),
        .has_dest  (has_dest),
        .new_tag   (new_tag),
        .old_tag   (old_tag)
    );

    exec_unit exec_unit_0 (
        .clock     (clock),
        .reset     (reset),
        .accept    (accept),
        .op        (op),
        .src1_tag  (src1_tag),
        .src2_tag  (src2_tag),
        .imm       (imm),
        .rd        (rd),
        .has_dest  (has_dest),
        .new_tag   (new_tag),
        .old_tag   (old_tag),
        .mult_start(mult_start),
        .mult_busy (mult_busy),
        .mult_done (mult_done),
        .alu_done  (alu_done),
        .rob_wr    (rob_wr_bus.source)
    );

    reorder_buffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) reorder_buffer_0 (
        .clock          (clock),
        .reset          (reset),
        .rob_wr         (rob_wr_bus.sink),
        .rob_full       (rob_full),
        .free_valid     (free_valid),
        .free_tag       (free_tag),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_has_dest(commit_has_dest),
        .commit_data    (commit_data)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic reset
);

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Held over RESET_CYCLES rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/100ps

module tb_checker (
    input  logic                clock,
    input  logic                reset,
    input  logic                instr_taken,
    input  logic                commit_valid,
    input  core_pkg::arch_reg_t commit_rd,
    input  logic                commit_has_dest,
    input  core_pkg::word_t     commit_data,
    input  logic                exp_push,
    input  core_pkg::arch_reg_t exp_rd,
    input  logic                exp_has_dest,
    input  core_pkg::word_t     exp_data,
    output int                  commit_count,
    output int                  error_count
);

    // Expected commits in program order
    core_pkg::arch_reg_t q_rd [$];
    logic                q_has_dest [$];
    core_pkg::word_t     q_data [$];

    core_pkg::arch_reg_t want_rd;
    logic                want_dest;
    core_pkg::word_t     want_data;

    // Reset as seen at the last two rising edges
    logic                reset_q  = 1'b1;
    logic                reset_qq = 1'b1;

    int                  commits = 0;
    int                  errors  = 0;

    assign commit_count = commits;
    assign error_count  = errors;

    ////////////////////
    // Expected side
    ////////////////////

    always @(posedge clock) begin
        reset_q  <= reset;
        reset_qq <= reset_q;
        if (exp_push) begin
            q_rd.push_back(exp_rd);
            q_has_dest.push_back(exp_has_dest);
            q_data.push_back(exp_data);
        end
    end

    ////////////////////
    // Commit side
    ////////////////////

    // Falling edge, commit outputs settled
    always @(negedge clock) begin
        // Nothing consumed before the first edge out of reset
        if (reset_q && instr_taken) begin
            $display("ERROR: instr_taken high during reset or the cycle after it");
            errors++;
        end
        if ((reset_q || reset_qq) && commit_valid) begin
            $display("ERROR: commit_valid high during reset or the cycle after it");
            errors++;
        end
        if (commit_valid) begin
            if (q_rd.size() == 0) begin
                $display("ERROR: a commit arrived with no instruction left to expect");
                errors++;
            end else begin
                want_rd   = q_rd.pop_front();
                want_dest = q_has_dest.pop_front();
                want_data = q_data.pop_front();
                if (commit_rd !== want_rd) begin
                    $display("CHECK FAILED commit_rd: expected 0x%h, got 0x%h (commit %0d)",
                             want_rd, commit_rd, commits);
                    errors++;
                end
                if (commit_has_dest !== want_dest) begin
                    $display("CHECK FAILED commit_has_dest: expected 0x%h, got 0x%h (commit %0d)",
                             want_dest, commit_has_dest, commits);
                    errors++;
                end
                // Data only means something with a destination
                if (want_dest && commit_data !== want_data) begin
                    $display("CHECK FAILED commit_data: expected 0x%h, got 0x%h (commit %0d)",
                             want_data, commit_data, commits);
                    errors++;
                end
                commits++;
            end
        end
    end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/100ps

module tb_top;

    localparam int NUM_INSTRS     = 300;
    // 40 cycles per instruction covers a multiply, plus reset margin
    localparam int TIMEOUT_CYCLES = NUM_INSTRS * 40 + 200;
    localparam int DRAIN_CYCLES   = 20;

    logic                clock;
    logic                reset;

    // DUT inputs and outputs
    core_pkg::word_t     instr;
    logic                instr_valid;
    logic                instr_taken;
    logic                commit_valid;
    core_pkg::arch_reg_t commit_rd;
    logic                commit_has_dest;
    core_pkg::word_t     commit_data;

    // Expected-value channel to the checker
    logic                exp_push;
    core_pkg::arch_reg_t exp_rd;
    logic                exp_has_dest;
    core_pkg::word_t     exp_data;
    int                  commit_count;
    int                  error_count;

    // Reference register state, x0 never written
    core_pkg::word_t     arch_regs [core_pkg::NUM_ARCH_REGS];

    logic                taken_q = 1'b0;
    int                  cycle_count = 0;
    int                  instrs_sent = 0;

    tb_clock_gen clock_gen_0 (
        .clock(clock),
        .reset(reset)
    );

    core_top #(
        .ROB_DEPTH(8)
    ) DUT (
        .clock          (clock),
        .reset          (reset),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .instr_taken    (instr_taken),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_has_dest(commit_has_dest),
        .commit_data    (commit_data)
    );

    tb_checker checker_0 (
        .clock          (clock),
        .reset          (reset),
        .instr_taken    (instr_taken),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_has_dest(commit_has_dest),
        .commit_data    (commit_data),
        .exp_push       (exp_push),
        .exp_rd         (exp_rd),
        .exp_has_dest   (exp_has_dest),
        .exp_data       (exp_data),
        .commit_count   (commit_count),
        .error_count    (error_count)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Top four bits of a draw pick the operation
    function automatic core_pkg::op_t pick_op(input logic [3:0] sel);
        case (sel)
            4'd0, 4'd1, 4'd2: return core_pkg::OP_ADD;
            4'd3, 4'd4:       return core_pkg::OP_SUB;
            4'd5, 4'd6:       return core_pkg::OP_AND;
            4'd7:             return core_pkg::OP_OR;
            4'd8, 4'd9:       return core_pkg::OP_XOR;
            4'd10:            return core_pkg::OP_MUL;
            4'd14:            return core_pkg::OP_NONE;
            default:          return core_pkg::OP_ADDI;
        endcase
    endfunction

    function automatic core_pkg::word_t encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                                 input core_pkg::arch_reg_t rd,
                                                 input core_pkg::arch_reg_t rs1,
                                                 input core_pkg::arch_reg_t rs2);
        return {f7, rs2, rs1, f3, rd, core_pkg::OPC_RTYPE};
    endfunction

    function automatic core_pkg::word_t encode_i(input logic [11:0] imm12, input logic [2:0] f3,
                                                 input core_pkg::arch_reg_t rd,
                                                 input core_pkg::arch_reg_t rs1,
                                                 input logic [6:0] opc);
        return {imm12, rs1, f3, rd, opc};
    endfunction

    // Expected result from the instruction set rules
    function automatic core_pkg::word_t ref_result(input core_pkg::op_t kind,
                                                   input core_pkg::word_t a,
                                                   input core_pkg::word_t b,
                                                   input core_pkg::word_t imm);
        case (kind)
            core_pkg::OP_ADD:  return a + b;
            core_pkg::OP_SUB:  return a - b;
            core_pkg::OP_AND:  return a & b;
            core_pkg::OP_OR:   return a | b;
            core_pkg::OP_XOR:  return a ^ b;
            // Low half of the product
            core_pkg::OP_MUL:  return a * b;
            core_pkg::OP_ADDI: return a + imm;
            default:           return '0;
        endcase
    endfunction

    // Call on a falling edge, returns on the falling edge after the take
    task automatic offer_instr(input core_pkg::word_t word, input core_pkg::arch_reg_t rd,
                               input logic has_dest, input core_pkg::word_t data);
        instr        = word;
        instr_valid  = 1'b1;
        exp_rd       = rd;
        exp_has_dest = has_dest;
        exp_data     = data;
        exp_push     = 1'b1;
        instrs_sent++;
        @(negedge clock);
        exp_push = 1'b0;
        // Hold the word under back-pressure
        while (!taken_q) begin
            @(negedge clock);
        end
    endtask

    task automatic print_summary(input int timeouts);
        $display("Summary: %0d sent, %0d committed, %0d errors, %0d timeouts",
                 instrs_sent, commit_count, error_count, timeouts);
    endtask

    // Take as a flop would see it
    always @(posedge clock) begin
        taken_q <= instr_taken;
    end

    ////////////////////
    // Timeout
    ////////////////////

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_summary(1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : stimulus
        logic [31:0]         seed;
        logic [31:0]         draw;
        logic [11:0]         imm12;
        core_pkg::op_t       kind;
        core_pkg::arch_reg_t rd;
        core_pkg::arch_reg_t rs1;
        core_pkg::arch_reg_t rs2;
        core_pkg::word_t     word;
        core_pkg::word_t     imm;
        core_pkg::word_t     value;
        logic                has_dest;

        instr        = '0;
        instr_valid  = 1'b0;
        exp_push     = 1'b0;
        exp_rd       = '0;
        exp_has_dest = 1'b0;
        exp_data     = '0;
        seed         = 32'h6b1d;
        for (int i = 0; i < core_pkg::NUM_ARCH_REGS; i++) begin
            arch_regs[i] = '0;
        end

        // First word is offered while reset is still high
        @(negedge clock);
        for (int n = 0; n < NUM_INSTRS; n++) begin
            seed  = lcg_next(seed);
            draw  = seed;
            seed  = lcg_next(seed);
            imm12 = seed[31:20];
            kind  = pick_op(draw[31:28]);
            // Registers x0..x7 only, for dense dependencies and x0 traffic
            rd    = {2'b00, draw[26:24]};
            rs1   = {2'b00, draw[22:20]};
            rs2   = {2'b00, draw[18:16]};
            imm   = {{20{imm12[11]}}, imm12};
            case (kind)
                core_pkg::OP_ADD:
                    word = encode_r(core_pkg::F7_BASE, core_pkg::F3_ADD_SUB, rd, rs1, rs2);
                core_pkg::OP_SUB:
                    word = encode_r(core_pkg::F7_SUB, core_pkg::F3_ADD_SUB, rd, rs1, rs2);
                core_pkg::OP_AND:
                    word = encode_r(core_pkg::F7_BASE, core_pkg::F3_AND, rd, rs1, rs2);
                core_pkg::OP_OR:
                    word = encode_r(core_pkg::F7_BASE, core_pkg::F3_OR, rd, rs1, rs2);
                core_pkg::OP_XOR:
                    word = encode_r(core_pkg::F7_BASE, core_pkg::F3_XOR, rd, rs1, rs2);
                core_pkg::OP_MUL:
                    word = encode_r(core_pkg::F7_MULDIV, core_pkg::F3_MUL, rd, rs1, rs2);
                core_pkg::OP_ADDI:
                    word = encode_i(imm12, core_pkg::F3_ADDI, rd, rs1, core_pkg::OPC_ITYPE);
                default: begin
                    // Load opcode or an R-type funct pair that does not exist
                    if (draw[27]) begin
                        word = encode_i(imm12, 3'b010, rd, rs1, 7'b0000011);
                    end else begin
                        word = encode_r(core_pkg::F7_SUB, core_pkg::F3_XOR, rd, rs1, rs2);
                    end
                end
            endcase
            has_dest = (kind != core_pkg::OP_NONE) && (rd != '0);
            value    = ref_result(kind, arch_regs[rs1], arch_regs[rs2], imm);
            if (has_dest) begin
                arch_regs[rd] = value;
            end
            offer_instr(word, rd, has_dest, value);
        end
        instr_valid = 1'b0;

        // Wait for the last commit, then watch for strays
        while (commit_count < NUM_INSTRS) begin
            @(negedge clock);
        end
        repeat (DRAIN_CYCLES) @(negedge clock);

        print_summary(0);
        if (error_count == 0 && commit_count == NUM_INSTRS) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- flist.f
verilog/core_pkg.sv
verilog/rob_write_if.sv
verilog/dispatch_ctrl.sv
verilog/mult_counter.sv
verilog/rename_unit.sv
verilog/exec_unit.sv
verilog/reorder_buffer.sv
verilog/core_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_top -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_top)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "^PASS: all tests$"; then
    exit 0
fi
exit 1
